//--- design/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

  localparam int ADDR_W   = 32;
  localparam int DOMAIN_W = 4;
  localparam int AP_W     = 2;
  localparam int FSR_W    = 4;

  typedef enum logic [1:0]
  {
    IDLE,
    LEVEL1,
    LEVEL2,
    ACCESS
  } walk_state_t;

  // descriptor type, bits 1:0
  localparam logic [1:0] DESC_FAULT   = 2'b00;
  localparam logic [1:0] DESC_COARSE  = 2'b01;
  localparam logic [1:0] DESC_SECTION = 2'b10;
  localparam logic [1:0] DESC_LARGE   = 2'b01;
  localparam logic [1:0] DESC_SMALL   = 2'b10;

  // fault status codes
  localparam logic [FSR_W-1:0] FS_TRANS_SECT = 4'b0101;
  localparam logic [FSR_W-1:0] FS_TRANS_PAGE = 4'b0111;
  localparam logic [FSR_W-1:0] FS_DOM_SECT   = 4'b1001;
  localparam logic [FSR_W-1:0] FS_DOM_PAGE   = 4'b1011;
  localparam logic [FSR_W-1:0] FS_PERM_SECT  = 4'b1101;
  localparam logic [FSR_W-1:0] FS_PERM_PAGE  = 4'b1111;

  // cp15 register numbers, all at opcode2 0
  localparam logic [3:0] CRN_ID   = 4'd0;
  localparam logic [3:0] CRN_CTRL = 4'd1;
  localparam logic [3:0] CRN_TTB  = 4'd2;
  localparam logic [3:0] CRN_DACR = 4'd3;
  localparam logic [3:0] CRN_FSR  = 4'd5;

  // domain access modes
  localparam logic [1:0] DOM_NONE     = 2'b00;
  localparam logic [1:0] DOM_CLIENT   = 2'b01;
  localparam logic [1:0] DOM_RESERVED = 2'b10;
  localparam logic [1:0] DOM_MANAGER  = 2'b11;

endpackage

`default_nettype wire

//--- design/access_check.sv
`timescale 1ns/1ps
`default_nettype none

module access_check
  import mmu_pkg::*;
(
  input  logic [DOMAIN_W-1:0] i_domain,
  input  logic [ADDR_W-1:0]   i_dacr,
  input  logic [AP_W-1:0]     i_ap,
  input  logic                i_privileged,
  input  logic                i_write,
  output logic                o_allow,
  output logic                o_domain_fault
);

  logic [1:0] dom_mode;
  logic       ap_ok;

  // two bits per domain
  assign dom_mode = i_dacr[{i_domain, 1'b0} +: 2];

  always_comb
  begin
    case (i_ap)
      2'b00: ap_ok = 1'b0;
      2'b01: ap_ok = i_privileged;
      2'b10: ap_ok = i_privileged || !i_write;
      default: ap_ok = 1'b1;
    endcase
  end

  always_comb
  begin
    case (dom_mode)
      DOM_MANAGER:
      begin
        o_allow        = 1'b1;
        o_domain_fault = 1'b0;
      end
      DOM_CLIENT:
      begin
        o_allow        = ap_ok;
        o_domain_fault = 1'b0;
      end
      DOM_NONE, DOM_RESERVED:
      begin
        o_allow        = 1'b0;
        o_domain_fault = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/cp15_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp15_regs
  import mmu_pkg::*;
#(
  parameter logic [ADDR_W-1:0] P_ID_VALUE = 32'h4107_8000
)
(
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_cp_sel,
  input  logic                i_cp_write,
  input  logic [3:0]          i_crn,
  input  logic [2:0]          i_opcode2,
  input  logic [ADDR_W-1:0]   i_cp_wdata,
  output logic [ADDR_W-1:0]   o_cp_rdata,
  input  logic                i_fault,
  input  logic [FSR_W-1:0]    i_fault_code,
  input  logic [DOMAIN_W-1:0] i_fault_domain,
  input  logic                i_fault_write,
  output logic                o_mmu_en,
  output logic [ADDR_W-1:14]  o_ttb,
  output logic [ADDR_W-1:0]   o_dacr
);

  logic                cp_wr;
  logic                ctrl_en_q;
  logic [ADDR_W-1:14]  ttb_q;
  logic [ADDR_W-1:0]   dacr_q;
  logic                fsr_write_q;
  logic [DOMAIN_W-1:0] fsr_domain_q;
  logic [FSR_W-1:0]    fsr_code_q;

  assign cp_wr = i_cp_sel && i_cp_write && (i_opcode2 == 3'd0);

  always_ff @(posedge i_clk or posedge i_rst)
  begin
    if (i_rst)
    begin
      ctrl_en_q <= 1'b0;
      ttb_q     <= '0;
      dacr_q    <= '0;
    end
    else if (cp_wr)
    begin
      case (i_crn)
        CRN_CTRL: ctrl_en_q <= i_cp_wdata[0];
        CRN_TTB:  ttb_q     <= i_cp_wdata[ADDR_W-1:14];
        CRN_DACR: dacr_q    <= i_cp_wdata;
        default:  ;
      endcase
    end
  end

  // a walker fault takes priority over a software write
  always_ff @(posedge i_clk or posedge i_rst)
  begin
    if (i_rst)
    begin
      fsr_write_q  <= 1'b0;
      fsr_domain_q <= '0;
      fsr_code_q   <= '0;
    end
    else if (i_fault)
    begin
      fsr_write_q  <= i_fault_write;
      fsr_domain_q <= i_fault_domain;
      fsr_code_q   <= i_fault_code;
    end
    else if (cp_wr && (i_crn == CRN_FSR))
    begin
      fsr_write_q  <= i_cp_wdata[11];
      fsr_domain_q <= i_cp_wdata[7:4];
      fsr_code_q   <= i_cp_wdata[3:0];
    end
  end

  always_comb
  begin
    o_cp_rdata = '0;
    if (i_cp_sel && (i_opcode2 == 3'd0))
    begin
      case (i_crn)
        CRN_ID:   o_cp_rdata = P_ID_VALUE;
        CRN_CTRL: o_cp_rdata = {{(ADDR_W-1){1'b0}}, ctrl_en_q};
        CRN_TTB:  o_cp_rdata = {ttb_q, 14'b0};
        CRN_DACR: o_cp_rdata = dacr_q;
        CRN_FSR:  o_cp_rdata = {20'b0, fsr_write_q, 3'b0, fsr_domain_q, fsr_code_q};
        default:  o_cp_rdata = '0;
      endcase
    end
  end

  assign o_mmu_en = ctrl_en_q;
  assign o_ttb    = ttb_q;
  assign o_dacr   = dacr_q;

endmodule

`default_nettype wire

//--- design/table_walker.sv
`timescale 1ns/1ps
`default_nettype none

module table_walker
  import mmu_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_req,
  input  logic                i_write,
  input  logic [ADDR_W-1:0]   i_va,
  input  logic [ADDR_W-1:0]   i_wdata,
  output logic [ADDR_W-1:0]   o_rdata,
  output logic                o_ack,
  output logic                o_fault,
  output logic                o_mem_req,
  output logic                o_mem_write,
  output logic [ADDR_W-1:0]   o_mem_addr,
  output logic [ADDR_W-1:0]   o_mem_wdata,
  input  logic [ADDR_W-1:0]   i_mem_rdata,
  input  logic                i_mem_ack,
  input  logic                i_mmu_en,
  input  logic [ADDR_W-1:14]  i_ttb,
  input  logic                i_allow,
  input  logic                i_domain_fault,
  output logic [FSR_W-1:0]    o_fault_code,
  output logic [DOMAIN_W-1:0] o_fault_domain,
  output logic                o_fault_write,
  output logic [DOMAIN_W-1:0] o_domain,
  output logic [AP_W-1:0]     o_ap
);

  walk_state_t         state_q;
  walk_state_t         state_d;
  logic [ADDR_W-1:0]   addr_q;
  logic [ADDR_W-1:0]   addr_d;
  logic [DOMAIN_W-1:0] domain_q;
  logic [1:0]          desc_type;
  logic [ADDR_W-1:0]   l1_addr;
  logic                bypass;
  logic                data_phase;

  assign desc_type  = i_mem_rdata[1:0];
  assign l1_addr    = {i_ttb, i_va[31:20], 2'b00};
  assign bypass     = !i_mmu_en && (state_q == IDLE);
  assign data_phase = bypass || (state_q == ACCESS);

  // level one checks the fetched section, level two the stored domain
  assign o_domain = (state_q == LEVEL1) ? i_mem_rdata[8:5] : domain_q;
  assign o_ap     = (state_q == LEVEL1) ? i_mem_rdata[11:10] : i_mem_rdata[5:4];

  assign o_fault_domain = o_domain;
  assign o_fault_write  = i_write;

  always_comb
  begin
    state_d      = state_q;
    addr_d       = addr_q;
    o_fault      = 1'b0;
    o_fault_code = FS_TRANS_SECT;
    case (state_q)
      IDLE:
      begin
        if (i_mmu_en && i_req)
          state_d = LEVEL1;
      end
      LEVEL1:
      begin
        if (i_mem_ack)
        begin
          case (desc_type)
            DESC_COARSE:
            begin
              state_d = LEVEL2;
              addr_d  = {i_mem_rdata[31:10], i_va[19:12], 2'b00};
            end
            DESC_SECTION:
            begin
              if (i_domain_fault || !i_allow)
              begin
                o_fault      = 1'b1;
                o_fault_code = i_domain_fault ? FS_DOM_SECT : FS_PERM_SECT;
                state_d      = IDLE;
              end
              else
              begin
                state_d = ACCESS;
                addr_d  = {i_mem_rdata[31:20], i_va[19:0]};
              end
            end
            default:
            begin
              // fault or the unused 11 encoding
              o_fault      = 1'b1;
              o_fault_code = FS_TRANS_SECT;
              state_d      = IDLE;
            end
          endcase
        end
      end
      LEVEL2:
      begin
        if (i_mem_ack)
        begin
          if (desc_type == DESC_FAULT)
          begin
            o_fault      = 1'b1;
            o_fault_code = FS_TRANS_PAGE;
            state_d      = IDLE;
          end
          else if (i_domain_fault || !i_allow)
          begin
            o_fault      = 1'b1;
            o_fault_code = i_domain_fault ? FS_DOM_PAGE : FS_PERM_PAGE;
            state_d      = IDLE;
          end
          else
          begin
            state_d = ACCESS;
            case (desc_type)
              DESC_SMALL: addr_d = {i_mem_rdata[31:12], i_va[11:0]};
              // 11 maps as a large page too
              DESC_LARGE, 2'b11: addr_d = {i_mem_rdata[31:16], i_va[15:0]};
              default: addr_d = addr_q;
            endcase
          end
        end
      end
      ACCESS:
      begin
        if (i_mem_ack)
          state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk or posedge i_rst)
  begin
    if (i_rst)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge i_clk)
  begin
    addr_q <= addr_d;
    if ((state_q == LEVEL1) && i_mem_ack)
      domain_q <= i_mem_rdata[8:5];
  end

  // descriptor fetches are reads, bypass follows the cpu directly
  assign o_mem_req   = bypass ? i_req : (state_q != IDLE);
  assign o_mem_addr  = bypass ? i_va : ((state_q == LEVEL1) ? l1_addr : addr_q);
  assign o_mem_write = data_phase ? i_write : 1'b0;
  assign o_mem_wdata = i_wdata;

  assign o_ack   = data_phase && i_mem_ack;
  assign o_rdata = o_ack ? i_mem_rdata : '0;

endmodule

`default_nettype wire

//--- design/mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_top
  import mmu_pkg::*;
#(
  parameter logic [ADDR_W-1:0] P_ID_VALUE = 32'h4107_8000
)
(
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_req,
  input  logic              i_write,
  input  logic              i_privileged,
  input  logic [ADDR_W-1:0] i_va,
  input  logic [ADDR_W-1:0] i_wdata,
  output logic [ADDR_W-1:0] o_rdata,
  output logic              o_ack,
  output logic              o_fault,
  output logic              o_mem_req,
  output logic              o_mem_write,
  output logic [ADDR_W-1:0] o_mem_addr,
  output logic [ADDR_W-1:0] o_mem_wdata,
  input  logic [ADDR_W-1:0] i_mem_rdata,
  input  logic              i_mem_ack,
  input  logic              i_cp_sel,
  input  logic              i_cp_write,
  input  logic [3:0]        i_crn,
  input  logic [2:0]        i_opcode2,
  input  logic [ADDR_W-1:0] i_cp_wdata,
  output logic [ADDR_W-1:0] o_cp_rdata
);

  logic                mmu_en;
  logic [ADDR_W-1:14]  ttb;
  logic [ADDR_W-1:0]   dacr;
  logic [FSR_W-1:0]    fault_code;
  logic [DOMAIN_W-1:0] fault_domain;
  logic                fault_write;
  logic [DOMAIN_W-1:0] chk_domain;
  logic [AP_W-1:0]     chk_ap;
  logic                allow;
  logic                domain_fault;

  cp15_regs #(
    .P_ID_VALUE (P_ID_VALUE)
  ) u_cp15_regs (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_cp_sel       (i_cp_sel),
    .i_cp_write     (i_cp_write),
    .i_crn          (i_crn),
    .i_opcode2      (i_opcode2),
    .i_cp_wdata     (i_cp_wdata),
    .o_cp_rdata     (o_cp_rdata),
    .i_fault        (o_fault),
    .i_fault_code   (fault_code),
    .i_fault_domain (fault_domain),
    .i_fault_write  (fault_write),
    .o_mmu_en       (mmu_en),
    .o_ttb          (ttb),
    .o_dacr         (dacr)
  );

  table_walker u_table_walker (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_req          (i_req),
    .i_write        (i_write),
    .i_va           (i_va),
    .i_wdata        (i_wdata),
    .o_rdata        (o_rdata),
    .o_ack          (o_ack),
    .o_fault        (o_fault),
    .o_mem_req      (o_mem_req),
    .o_mem_write    (o_mem_write),
    .o_mem_addr     (o_mem_addr),
    .o_mem_wdata    (o_mem_wdata),
    .i_mem_rdata    (i_mem_rdata),
    .i_mem_ack      (i_mem_ack),
    .i_mmu_en       (mmu_en),
    .i_ttb          (ttb),
    .i_allow        (allow),
    .i_domain_fault (domain_fault),
    .o_fault_code   (fault_code),
    .o_fault_domain (fault_domain),
    .o_fault_write  (fault_write),
    .o_domain       (chk_domain),
    .o_ap           (chk_ap)
  );

  access_check u_access_check (
    .i_domain       (chk_domain),
    .i_dacr         (dacr),
    .i_ap           (chk_ap),
    .i_privileged   (i_privileged),
    .i_write        (i_write),
    .o_allow        (allow),
    .o_domain_fault (domain_fault)
  );

endmodule

`default_nettype wire

//--- test/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen
(
  output logic o_clk,
  output logic o_rst
);

  logic clk = 1'b0;
  logic rst = 1'b1;

  // 20 ns period
  always #10 clk = ~clk;

  initial
  begin
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

  assign o_clk = clk;
  assign o_rst = rst;

endmodule

`default_nettype wire

//--- test/mmu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_asserts
  import mmu_pkg::*;
(
  input logic              i_clk,
  input logic              i_rst,
  input logic              i_ack,
  input logic              i_fault,
  input logic              i_mem_ack,
  input logic              i_mem_req,
  input logic [ADDR_W-1:0] i_mem_addr
);

  int unsigned fail_count = 0;

  a_ack_fault_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_ack && i_fault))
  else
  begin
    $error("o_ack and o_fault are high in the same cycle");
    fail_count++;
  end

  // completion only in the cycle of a memory ack
  a_done_on_mem_ack: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_ack || i_fault) |-> i_mem_ack)
  else
  begin
    $error("o_ack or o_fault without i_mem_ack");
    fail_count++;
  end

  a_addr_held: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_mem_req && !i_mem_ack) |=> (i_mem_req && $stable(i_mem_addr)))
  else
  begin
    $error("o_mem_req or o_mem_addr changed before the ack");
    fail_count++;
  end

endmodule

bind mmu_top mmu_asserts u_mmu_asserts (
  .i_clk      (i_clk),
  .i_rst      (i_rst),
  .i_ack      (o_ack),
  .i_fault    (o_fault),
  .i_mem_ack  (i_mem_ack),
  .i_mem_req  (o_mem_req),
  .i_mem_addr (o_mem_addr)
);

`default_nettype wire

//--- test/mmu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_tb
  import mmu_pkg::*;
();

  localparam logic [31:0] ID_VALUE = 32'h4107_8000;
  localparam logic [31:0] SEED     = 32'hbbca_3b12;
  localparam logic [31:0] TTB_BASE = 32'h0010_0000;
  localparam int          TIMEOUT  = 200;

  logic        clk;
  logic        rst;
  logic        req;
  logic        wr;
  logic        priv;
  logic [31:0] va;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic        ack;
  logic        fault;
  logic        mem_req;
  logic        mem_write;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;
  logic        mem_ack;
  logic        cp_sel;
  logic        cp_write;
  logic [3:0]  crn;
  logic [2:0]  opcode2;
  logic [31:0] cp_wdata;
  logic [31:0] cp_rdata;

  logic [31:0] mem [logic [31:0]];
  logic [31:0] log_addr[$];
  logic        log_write[$];
  logic [31:0] log_wdata[$];
  logic [31:0] exp_addr[$];
  int          mem_wait;
  int          mismatches;
  int          other_errors;
  logic        stop_run;
  logic        mmu_on;
  logic [31:0] ttb_model;
  logic [31:0] dacr_model;

  clk_gen u_clk_gen (
    .o_clk (clk),
    .o_rst (rst)
  );

  mmu_top uut (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_req        (req),
    .i_write      (wr),
    .i_privileged (priv),
    .i_va         (va),
    .i_wdata      (wdata),
    .o_rdata      (rdata),
    .o_ack        (ack),
    .o_fault      (fault),
    .o_mem_req    (mem_req),
    .o_mem_write  (mem_write),
    .o_mem_addr   (mem_addr),
    .o_mem_wdata  (mem_wdata),
    .i_mem_rdata  (mem_rdata),
    .i_mem_ack    (mem_ack),
    .i_cp_sel     (cp_sel),
    .i_cp_write   (cp_write),
    .i_crn        (crn),
    .i_opcode2    (opcode2),
    .i_cp_wdata   (cp_wdata),
    .o_cp_rdata   (cp_rdata)
  );

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got %08h expected %08h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic end_run();
    int asserts_failed;
    asserts_failed = int'(uut.u_mmu_asserts.fail_count);
    $display("errors: mismatches=%0d other=%0d assertions=%0d",
             mismatches, other_errors, asserts_failed);
    if (mismatches == 0 && other_errors == 0 && asserts_failed == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  endtask

  // untouched words hold a pattern of their own address
  function automatic logic [31:0] mem_read(input logic [31:0] a);
    if (mem.exists(a))
      return mem[a];
    return {a[15:0], a[31:16]} ^ 32'hc3a5_96f0;
  endfunction

  // memory model step at each rising edge of an access
  task automatic mem_step();
    if (mem_ack)
    begin
      log_addr.push_back(mem_addr);
      log_write.push_back(mem_write);
      log_wdata.push_back(mem_wdata);
      if (mem_write)
        mem[mem_addr] = mem_wdata;
      mem_ack  <= 1'b0;
      mem_wait = int'($urandom_range(3, 0));
    end
    else if (mem_req)
    begin
      if (mem_wait == 0)
      begin
        mem_ack   <= 1'b1;
        mem_rdata <= mem_read(mem_addr);
      end
      else
        mem_wait--;
    end
  endtask

  task automatic cp_write_reg(input logic [3:0] a_crn, input logic [31:0] a_data);
    @(posedge clk);
    cp_sel   <= 1'b1;
    cp_write <= 1'b1;
    crn      <= a_crn;
    opcode2  <= 3'd0;
    cp_wdata <= a_data;
    @(posedge clk);
    cp_sel   <= 1'b0;
    cp_write <= 1'b0;
  endtask

  task automatic cp_read_reg(input logic [3:0] a_crn, input logic [2:0] a_op2,
                             input logic a_sel, output logic [31:0] a_data);
    @(posedge clk);
    cp_sel   <= a_sel;
    cp_write <= 1'b0;
    crn      <= a_crn;
    opcode2  <= a_op2;
    @(posedge clk);
    a_data = cp_rdata;
    cp_sel <= 1'b0;
  endtask

  task automatic set_dacr(input logic [31:0] value);
    dacr_model = value;
    cp_write_reg(CRN_DACR, value);
  endtask

  // 0 allowed, 1 domain fault, 2 permission fault
  function automatic logic [1:0] judge(input logic [3:0] dom, input logic [1:0] ap,
                                       input logic a_priv, input logic a_wr);
    logic [1:0] mode;
    logic       ok;
    mode = dacr_model[2*int'(dom) +: 2];
    if (mode == DOM_MANAGER)
      return 2'd0;
    if (mode != DOM_CLIENT)
      return 2'd1;
    ok = (ap == 2'b11) || (a_priv && ap != 2'b00) || (ap == 2'b10 && !a_wr);
    return ok ? 2'd0 : 2'd2;
  endfunction

  function automatic logic [31:0] l1_slot(input logic [31:0] a_va);
    return {ttb_model[31:14], a_va[31:20], 2'b00};
  endfunction

  // mapped pages sit above 2 GB and tables below
  task automatic map_section(input logic [31:0] a_va, input logic [3:0] dom,
                             input logic [1:0] ap);
    logic [31:0] r;
    r = $urandom;
    mem[l1_slot(a_va)] = {1'b1, r[30:20], 8'h00, ap, 1'b0, dom, 3'b000, 2'b10};
  endtask

  task automatic map_coarse(input logic [31:0] a_va, input logic [3:0] dom,
                            input logic [1:0] kind, input logic [1:0] ap);
    logic [31:0] r;
    logic [31:0] base;
    r    = $urandom;
    base = {12'h002, r[19:10], 10'h000};
    mem[l1_slot(a_va)] = {base[31:10], 1'b0, dom, 3'b000, 2'b01};
    r = $urandom;
    mem[{base[31:10], a_va[19:12], 2'b00}] = {1'b1, r[30:6], ap, r[3:2], kind};
  endtask

  task automatic map_l1_fault(input logic [31:0] a_va, input logic [3:0] dom,
                              input logic [1:0] typ);
    logic [31:0] r;
    r = $urandom;
    mem[l1_slot(a_va)] = {r[31:9], dom, r[4:2], typ};
  endtask

  task automatic map_random(input logic [31:0] a_va, input logic [3:0] dom,
                            input logic [1:0] ap);
    logic [31:0] r;
    r = $urandom;
    case (r[1:0])
      2'b00: map_coarse(a_va, dom, 2'b10, ap);
      2'b01: map_coarse(a_va, dom, 2'b01, ap);
      2'b10: map_coarse(a_va, dom, 2'b11, ap);
      default: map_section(a_va, dom, ap);
    endcase
  endtask

  // reference model of the walk and its expected transfers
  task automatic predict(input logic [31:0] a_va, input logic a_wr, input logic a_priv,
                         output logic e_fault, output logic [31:0] e_fsr);
    logic [31:0] d1;
    logic [31:0] l2a;
    logic [31:0] d2;
    logic [31:0] pa;
    logic [1:0]  verdict;
    logic        page;
    logic [3:0]  code;
    exp_addr.delete();
    e_fault = 1'b0;
    e_fsr   = 32'h0;
    if (!mmu_on)
    begin
      exp_addr.push_back(a_va);
      return;
    end
    d1 = mem_read(l1_slot(a_va));
    exp_addr.push_back(l1_slot(a_va));
    page = 1'b0;
    pa   = 32'h0;
    verdict = 2'd3;
    if (d1[1:0] == 2'b10)
    begin
      verdict = judge(d1[8:5], d1[11:10], a_priv, a_wr);
      pa      = {d1[31:20], a_va[19:0]};
    end
    else if (d1[1:0] == 2'b01)
    begin
      page = 1'b1;
      l2a  = {d1[31:10], a_va[19:12], 2'b00};
      d2   = mem_read(l2a);
      exp_addr.push_back(l2a);
      if (d2[1:0] != 2'b00)
        verdict = judge(d1[8:5], d2[5:4], a_priv, a_wr);
      pa = (d2[1:0] == 2'b10) ? {d2[31:12], a_va[11:0]} : {d2[31:16], a_va[15:0]};
    end
    if (verdict == 2'd0)
      exp_addr.push_back(pa);
    else
    begin
      e_fault = 1'b1;
      case (verdict)
        2'd1: code = page ? FS_DOM_PAGE : FS_DOM_SECT;
        2'd2: code = page ? FS_PERM_PAGE : FS_PERM_SECT;
        default: code = page ? FS_TRANS_PAGE : FS_TRANS_SECT;
      endcase
      e_fsr = {20'h0, a_wr, 3'b000, d1[8:5], code};
    end
  endtask

  task automatic check_access(input logic [31:0] a_va, input logic a_wr, input logic a_priv);
    logic        e_fault;
    logic [31:0] e_fsr;
    logic [31:0] e_rdata;
    logic [31:0] wd;
    logic [31:0] got_fsr;
    logic        done;
    logic        is_data;
    int          cycles;
    if (stop_run)
      return;
    wd = $urandom;
    predict(a_va, a_wr, a_priv, e_fault, e_fsr);
    e_rdata = mem_read(exp_addr[exp_addr.size()-1]);
    log_addr.delete();
    log_write.delete();
    log_wdata.delete();
    @(posedge clk);
    req   <= 1'b1;
    wr    <= a_wr;
    priv  <= a_priv;
    va    <= a_va;
    wdata <= wd;
    done   = 1'b0;
    cycles = 0;
    while (!done)
    begin
      @(posedge clk);
      if (ack || fault)
      begin
        done = 1'b1;
        compare("o_fault", {31'h0, fault}, {31'h0, e_fault});
        if (ack && !a_wr)
          compare("o_rdata", rdata, e_rdata);
        req <= 1'b0;
      end
      else if (cycles >= TIMEOUT)
      begin
        $display("timeout: access to va %08h got neither ack nor fault", a_va);
        other_errors++;
        stop_run = 1'b1;
        done     = 1'b1;
        req     <= 1'b0;
      end
      cycles++;
      mem_step();
    end
    if (stop_run)
      return;
    compare("transfer count", log_addr.size(), exp_addr.size());
    for (int i = 0; i < log_addr.size() && i < exp_addr.size(); i++)
    begin
      is_data = !e_fault && (i == exp_addr.size() - 1);
      compare("o_mem_addr", log_addr[i], exp_addr[i]);
      compare("o_mem_write", {31'h0, log_write[i]}, {31'h0, is_data && a_wr});
      if (is_data && a_wr)
        compare("o_mem_wdata", log_wdata[i], wd);
    end
    if (e_fault)
    begin
      cp_read_reg(CRN_FSR, 3'd0, 1'b1, got_fsr);
      compare("fault status", got_fsr, e_fsr);
    end
  endtask

  initial
  begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] rd;
    int          cycles;
    void'($urandom(SEED));
    req          = 1'b0;
    wr           = 1'b0;
    priv         = 1'b0;
    va           = 32'h0;
    wdata        = 32'h0;
    mem_rdata    = 32'h0;
    mem_ack      = 1'b0;
    cp_sel       = 1'b0;
    cp_write     = 1'b0;
    crn          = 4'h0;
    opcode2      = 3'd0;
    cp_wdata     = 32'h0;
    mem_wait     = 0;
    mismatches   = 0;
    other_errors = 0;
    stop_run     = 1'b0;
    mmu_on       = 1'b0;
    ttb_model    = 32'h0;
    dacr_model   = 32'h0;

    cycles = 0;
    while (rst !== 1'b0 && !stop_run)
    begin
      @(posedge clk);
      cycles++;
      if (cycles > 40)
      begin
        $display("timeout: reset was never released");
        other_errors++;
        stop_run = 1'b1;
      end
    end
    @(posedge clk);
    compare("o_mem_req", {31'h0, mem_req}, 32'h0);
    compare("o_ack", {31'h0, ack}, 32'h0);
    compare("o_fault", {31'h0, fault}, 32'h0);

    // mmu off so accesses pass straight through
    repeat (20)
    begin
      r = $urandom;
      check_access($urandom, r[0], r[1]);
    end

    cp_read_reg(CRN_ID, 3'd0, 1'b1, rd);
    compare("id", rd, ID_VALUE);
    repeat (4)
    begin
      r = $urandom;
      cp_write_reg(CRN_TTB, r);
      cp_read_reg(CRN_TTB, 3'd0, 1'b1, rd);
      compare("ttb", rd, r & 32'hffff_c000);
      r = $urandom;
      cp_write_reg(CRN_DACR, r);
      cp_read_reg(CRN_DACR, 3'd0, 1'b1, rd);
      compare("dacr", rd, r);
      r = $urandom;
      cp_write_reg(CRN_CTRL, r);
      cp_read_reg(CRN_CTRL, 3'd0, 1'b1, rd);
      compare("control", rd, {31'h0, r[0]});
      r = $urandom;
      cp_write_reg(CRN_FSR, r);
      cp_read_reg(CRN_FSR, 3'd0, 1'b1, rd);
      compare("fault status", rd, r & 32'h0000_08ff);
    end
    for (int n = 4; n < 16; n++)
    begin
      if (n != 5)
      begin
        cp_read_reg(4'(n), 3'd0, 1'b1, rd);
        compare("unimplemented register", rd, 32'h0);
      end
    end
    cp_read_reg(CRN_ID, 3'd1, 1'b1, rd);
    compare("id at opcode2 1", rd, 32'h0);
    cp_read_reg(CRN_ID, 3'd0, 1'b0, rd);
    compare("id without select", rd, 32'h0);

    ttb_model = TTB_BASE;
    cp_write_reg(CRN_TTB, TTB_BASE);
    set_dacr(32'hffff_ffff);
    cp_write_reg(CRN_CTRL, 32'h1);
    mmu_on = 1'b1;

    // sections in manager domains
    repeat (30)
    begin
      a = $urandom;
      r = $urandom;
      map_section(a, r[3:0], r[5:4]);
      check_access(a, r[6], r[7]);
    end

    // coarse tables with small and large pages
    repeat (30)
    begin
      a = $urandom;
      r = $urandom;
      map_coarse(a, r[3:0], r[8] ? 2'b10 : (r[9] ? 2'b11 : 2'b01), r[5:4]);
      check_access(a, r[6], r[7]);
    end

    // translation faults at both levels
    repeat (16)
    begin
      a = $urandom;
      r = $urandom;
      if (r[8])
        map_l1_fault(a, r[3:0], r[4] ? 2'b11 : 2'b00);
      else
        map_coarse(a, r[3:0], 2'b00, r[5:4]);
      check_access(a, r[6], r[7]);
    end

    // domain none and then reserved
    for (int m = 0; m < 2; m++)
    begin
      set_dacr({16{(m == 0) ? DOM_NONE : DOM_RESERVED}});
      repeat (6)
      begin
        a = $urandom;
        r = $urandom;
        map_random(a, r[3:0], r[5:4]);
        check_access(a, r[6], r[7]);
      end
    end

    set_dacr({16{DOM_CLIENT}});
    for (int ap = 0; ap < 4; ap++)
      for (int pv = 0; pv < 2; pv++)
        for (int w = 0; w < 2; w++)
        begin
          a = $urandom;
          r = $urandom;
          map_section(a, r[3:0], 2'(ap));
          check_access(a, 1'(w), 1'(pv));
          a = $urandom;
          map_coarse(a, r[3:0], r[4] ? 2'b10 : 2'b01, 2'(ap));
          check_access(a, 1'(w), 1'(pv));
        end

    // mixed domain modes
    repeat (20)
    begin
      set_dacr($urandom);
      a = $urandom;
      r = $urandom;
      map_random(a, r[3:0], r[5:4]);
      check_access(a, r[6], r[7]);
    end

    end_run();
  end

endmodule

`default_nettype wire

//--- all.f
design/mmu_pkg.sv
design/access_check.sv
design/cp15_regs.sv
design/table_walker.sv
design/mmu_top.sv
test/clk_gen.sv
test/mmu_asserts.sv
test/mmu_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module mmu_tb \
  -f all.f --Mdir obj_dir -o mmu_sim > build.log 2>&1 &&
./obj_dir/mmu_sim +verilator+error+limit+1000 > sim.log 2>&1 ||
echo "build or simulation returned an error status, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "STATUS: PASS" sim.log 2>/dev/null && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}
